/* flist.f */
verilog/pcie_wr_pkg.sv
verilog/sync_fifo.sv
verilog/wr_tlp_splitter.sv
verilog/wr_credit_alloc.sv
verilog/wr_tlp_formatter.sv
verilog/pcie_outbound_write.sv
sim/tb_pcie_outbound_write.sv

/* Bender.yml */
package:
  name: pcie_outbound_write

sources:
  - verilog/pcie_wr_pkg.sv
  - verilog/sync_fifo.sv
  - verilog/wr_tlp_splitter.sv
  - verilog/wr_credit_alloc.sv
  - verilog/wr_tlp_formatter.sv
  - verilog/pcie_outbound_write.sv
  - target: test
    files:
      - sim/tb_pcie_outbound_write.sv

/* sim/tb_pcie_outbound_write.sv */
`timescale 1ns/1ns

module tb_pcie_outbound_write
    import pcie_wr_pkg::*;
();

    typedef struct packed {
        logic        sof;
        logic        eof;
        logic [31:0] data;
    } beat_t;

    logic            clk;
    logic            rst;
    logic            cmd_valid;
    logic            cmd_ready;
    wr_cmd_t         cmd;
    logic            wd_valid;
    logic            wd_ready;
    logic [31:0]     wd_data;
    logic [FCHB-1:0] fc_ph;
    logic [FCDB-1:0] fc_pd;
    logic            dma_en;
    logic [15:0]     req_id;
    logic            tx_valid;
    logic            tx_ready;
    logic [31:0]     tx_data;
    logic            tx_sof;
    logic            tx_eof;

    integer      seed = 32'h52b3;
    wr_cmd_t     cmd_q [$];   // commands not yet accepted
    logic [31:0] wd_q [$];    // payload words not yet accepted
    beat_t       exp_q [$];   // expected transmit beats
    logic        cmd_fire;
    logic        wd_fire;
    logic        quiet;       // no tx traffic allowed
    logic        bp_on;       // random tx_ready
    logic        stalled;
    beat_t       held;
    beat_t       cur;
    int          pkts_exp;
    int          pkts_seen;
    int          data_errs;
    int          proto_errs;
    int          timeouts;

    pcie_outbound_write dut (.*);

    always #50 clk = ~clk;

    // reference model of the splitting rule
    task automatic add_cmd(input logic [29:0] addr, input logic [9:0] len,
                           input logic [3:0] bf, input logic [3:0] bl);
        wr_cmd_t     c;
        logic [29:0] a;
        int          rem;
        int          seg;
        int          k;
        logic        first;
        logic [3:0]  tf;
        logic [3:0]  tl;
        logic [31:0] w;
        c = '{addr: addr, len: len, be_first: bf, be_last: bl};
        cmd_q.push_back(c);
        a     = addr;
        rem   = len;
        first = 1'b1;
        while (rem > 0) begin
            seg = 32 - a[4:0];  // up to the next 128 byte boundary
            if (rem < seg) seg = rem;
            tf = first ? bf : 4'hf;
            if (seg == 1) tl = 4'h0;
            else tl = (seg == rem) ? bl : 4'hf;
            exp_q.push_back({1'b1, 1'b0, 3'b010, 5'b00000, 14'd0, 10'(seg)});
            exp_q.push_back({1'b0, 1'b0, req_id, 8'h00, tl, tf});
            exp_q.push_back({1'b0, 1'b0, a, 2'b00});
            for (k = 0; k < seg; k++) begin
                w = $random(seed);
                wd_q.push_back(w);
                exp_q.push_back({1'b0, (k == seg - 1), w});
            end
            a     = a + 30'(seg);
            rem   = rem - seg;
            first = 1'b0;
            pkts_exp++;
        end
    endtask

    task automatic end_run();
        $display("errors: %0d data, %0d protocol, %0d timeout", data_errs, proto_errs, timeouts);
        if (data_errs + proto_errs + timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic check_beat(input beat_t got);
        beat_t e;
        if (exp_q.size() == 0) begin
            proto_errs++;
            $display("transmit beat %h arrived with no packet outstanding", got.data);
        end else begin
            e = exp_q.pop_front();
            assert (got.data == e.data) else begin
                data_errs++;
                $display("FAIL tx_data got %h expected %h", got.data, e.data);
            end
            assert (got.sof == e.sof && got.eof == e.eof) else begin
                proto_errs++;
                $display("FAIL tx_sof/tx_eof got %h/%h expected %h/%h",
                         got.sof, got.eof, e.sof, e.eof);
            end
        end
        if (got.sof) pkts_seen++;
    endtask

    task automatic wait_drained(input int limit);
        int t;
        t = 0;
        while ((exp_q.size() != 0 || cmd_q.size() != 0 || wd_q.size() != 0) && t < limit) begin
            @(posedge clk);
            t++;
        end
        if (exp_q.size() != 0 || cmd_q.size() != 0 || wd_q.size() != 0) begin
            timeouts++;
            $display("timed out waiting for all packets, %0d beats still missing", exp_q.size());
            end_run();
        end
    endtask

    // handshakes sampled mid cycle and applied after the next edge
    always @(negedge clk) begin
        cmd_fire <= !rst && cmd_valid && cmd_ready;
        wd_fire  <= !rst && wd_valid && wd_ready;
    end

    always @(posedge clk) begin
        logic bp;
        bp = bp_on;  // sampled before the main flow changes it
        #10;
        if (cmd_fire) void'(cmd_q.pop_front());
        if (wd_fire) void'(wd_q.pop_front());
        cmd_valid = (cmd_q.size() != 0);
        if (cmd_q.size() != 0) cmd = cmd_q[0];
        wd_valid = (wd_q.size() != 0);
        if (wd_q.size() != 0) wd_data = wd_q[0];
        tx_ready = bp ? (($random(seed) & 3) != 0) : 1'b1;
    end

    // transmit monitor samples half a cycle after the inputs change
    always @(negedge clk) begin
        cur = {tx_sof, tx_eof, tx_data};
        if (rst) begin
            stalled = 1'b0;
        end else begin
            if (stalled) begin
                assert (tx_valid && cur == held) else begin
                    proto_errs++;
                    $display("FAIL stalled beat tx_valid %h tx_data %h sof/eof %h/%h held %h %h/%h",
                             tx_valid, tx_data, tx_sof, tx_eof, held.data, held.sof, held.eof);
                end
            end
            if (tx_valid && tx_ready) check_beat(cur);
            stalled = tx_valid && !tx_ready;
            held    = cur;
        end
    end

    a_reset_quiet: assert property (@(posedge clk) rst |-> !tx_valid) else begin
        proto_errs++;
        $display("FAIL tx_valid 1 expected 0 during reset");
    end

    a_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> (cmd_ready && wd_ready))
    else begin
        proto_errs++;
        $display("FAIL cmd_ready %h wd_ready %h expected 1 after reset",
                 $sampled(cmd_ready), $sampled(wd_ready));
    end

    a_gate_quiet: assert property (@(posedge clk) disable iff (rst) quiet |-> !tx_valid) else begin
        proto_errs++;
        $display("FAIL tx_valid 1 expected 0 while credits or bus mastering are withheld");
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        wd_valid  = 1'b0;
        wd_data   = '0;
        fc_ph     = '0;
        fc_pd     = 12'd64;
        dma_en    = 1'b0;
        req_id    = 16'h01a5;
        tx_ready  = 1'b1;
        quiet     = 1'b1;
        bp_on     = 1'b0;
        cmd_fire  = 1'b0;
        wd_fire   = 1'b0;
        stalled   = 1'b0;
        add_cmd(30'h0000_0105, 10'd10, 4'he, 4'h3);     // first tlp needs 3 data credits
        add_cmd(30'h0000_0a1c, 10'd10, 4'hc, 4'h7);     // crosses a 32 dword boundary
        add_cmd(30'h0000_0400, 10'd1, 4'h6, 4'h0);      // single dword
        add_cmd(30'h0001_0007, 10'd1023, 4'h8, 4'h1);   // longest command
        repeat (4) begin
            add_cmd(30'($random(seed)), 10'(($random(seed) & 63) + 1), 4'($random(seed)), 4'hf);
        end
        repeat (4) @(posedge clk);
        #10 rst = 1'b0;
        repeat (50) @(posedge clk);  // bus mastering off
        #10 dma_en = 1'b1;
        repeat (50) @(posedge clk);  // no header credits
        #10;
        fc_ph = 8'd32;
        fc_pd = 12'd1;
        repeat (50) @(posedge clk);  // one data credit is too few
        #10;
        fc_pd = 12'd64;
        quiet = 1'b0;
        bp_on = 1'b1;
        wait_drained(20000);
        // second batch with full credits and bus mastering off
        quiet = 1'b1;
        repeat (3) begin
            add_cmd(30'($random(seed)), 10'(($random(seed) & 63) + 1), 4'($random(seed)), 4'hf);
        end
        #10 dma_en = 1'b0;
        repeat (50) @(posedge clk);
        #10;
        dma_en = 1'b1;
        quiet  = 1'b0;
        wait_drained(20000);
        assert (pkts_seen == pkts_exp) else begin
            data_errs++;
            $display("FAIL packet count %h expected %h", pkts_seen, pkts_exp);
        end
        end_run();
    end

endmodule

/* verilog/pcie_outbound_write.sv */
`timescale 1ns/1ns

module pcie_outbound_write
    import pcie_wr_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            cmd_valid,
    output logic            cmd_ready,
    input  wr_cmd_t         cmd,
    input  logic            wd_valid,
    output logic            wd_ready,
    input  logic [31:0]     wd_data,
    input  logic [FCHB-1:0] fc_ph,
    input  logic [FCDB-1:0] fc_pd,
    input  logic            dma_en,
    input  logic [15:0]     req_id,
    output logic            tx_valid,
    input  logic            tx_ready,
    output logic [31:0]     tx_data,
    output logic            tx_sof,
    output logic            tx_eof
);

    logic        cq_valid;    // command FIFO to splitter
    logic        cq_ready;
    wr_cmd_t     cq;
    logic        wq_valid;    // payload FIFO to splitter
    logic        wq_ready;
    logic [31:0] wq_data;
    logic        sh_valid;    // splitter to allocator
    logic        sh_ready;
    tlp_hdr_t    sh;
    logic        sd_valid;
    logic        sd_ready;
    logic [31:0] sd_data;
    logic        gh_valid;    // allocator to formatter
    logic        gh_ready;
    tlp_hdr_t    gh;
    logic        gd_valid;
    logic        gd_ready;
    logic [31:0] gd_data;

    sync_fifo #(.T(wr_cmd_t), .DEPTH(FIFO_DEPTH)) u_cmd_fifo (
        .clk, .rst,
        .in_valid(cmd_valid), .in_ready(cmd_ready), .in_data(cmd),
        .out_valid(cq_valid), .out_ready(cq_ready), .out_data(cq)
    );

    sync_fifo #(.T(logic [31:0]), .DEPTH(FIFO_DEPTH)) u_wd_fifo (
        .clk, .rst,
        .in_valid(wd_valid), .in_ready(wd_ready), .in_data(wd_data),
        .out_valid(wq_valid), .out_ready(wq_ready), .out_data(wq_data)
    );

    wr_tlp_splitter u_splitter (
        .clk, .rst,
        .cmd_valid(cq_valid), .cmd_ready(cq_ready), .cmd(cq),
        .wd_valid(wq_valid), .wd_ready(wq_ready), .wd_data(wq_data),
        .hdr_valid(sh_valid), .hdr_ready(sh_ready), .hdr(sh),
        .d_valid(sd_valid), .d_ready(sd_ready), .d_data(sd_data)
    );

    wr_credit_alloc u_alloc (
        .clk, .rst,
        .tlp_h_valid(sh_valid), .tlp_h_ready(sh_ready), .tlp_h(sh),
        .tlp_d_valid(sd_valid), .tlp_d_ready(sd_ready), .tlp_d_data(sd_data),
        .wr_h_valid(gh_valid), .wr_h_ready(gh_ready), .wr_h(gh),
        .wr_d_valid(gd_valid), .wr_d_ready(gd_ready), .wr_d_data(gd_data),
        .fc_ph, .fc_pd, .dma_en
    );

    wr_tlp_formatter u_formatter (
        .clk, .rst,
        .h_valid(gh_valid), .h_ready(gh_ready), .h(gh),
        .d_valid(gd_valid), .d_ready(gd_ready), .d_data(gd_data),
        .req_id,
        .tx_valid, .tx_ready, .tx_data, .tx_sof, .tx_eof
    );

endmodule

/* verilog/wr_tlp_formatter.sv */
`timescale 1ns/1ns

module wr_tlp_formatter
    import pcie_wr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        h_valid,
    output logic        h_ready,
    input  tlp_hdr_t    h,
    input  logic        d_valid,
    output logic        d_ready,
    input  logic [31:0] d_data,
    input  logic [15:0] req_id,
    output logic        tx_valid,
    input  logic        tx_ready,
    output logic [31:0] tx_data,
    output logic        tx_sof,
    output logic        tx_eof
);

    typedef enum logic [2:0] {
        st_idle,
        st_dw0,
        st_dw1,
        st_dw2,
        st_data
    } state_t;

    state_t      state;
    tlp_hdr_t    hq;      // header of the packet on the wire
    logic [10:0] cnt;     // payload words left
    logic        tx_xfer;
    logic [31:0] dw0;
    logic [31:0] dw1;
    logic [31:0] dw2;

    assign h_ready = (state == st_idle);
    assign tx_xfer = tx_valid && tx_ready;

    assign dw0 = {3'b010, 5'b00000, 14'd0, hq.len};  // MWr, 3dw with data
    assign dw1 = {req_id, 8'h00, hq.be_last, hq.be_first};
    assign dw2 = {hq.addr, 2'b00};

    always_comb begin
        tx_valid = 1'b0;
        tx_data  = 32'd0;
        tx_sof   = 1'b0;
        tx_eof   = 1'b0;
        d_ready  = 1'b0;
        case (state)
            st_dw0: begin
                tx_valid = 1'b1;
                tx_data  = dw0;
                tx_sof   = 1'b1;
            end
            st_dw1: begin
                tx_valid = 1'b1;
                tx_data  = dw1;
            end
            st_dw2: begin
                tx_valid = 1'b1;
                tx_data  = dw2;
            end
            st_data: begin
                tx_valid = d_valid;
                tx_data  = d_data;
                tx_eof   = (cnt == 11'd1);
                d_ready  = tx_ready;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (h_valid && h_ready) begin
            hq <= h;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: if (h_valid) state <= st_dw0;
                st_dw0:  if (tx_ready) state <= st_dw1;
                st_dw1:  if (tx_ready) state <= st_dw2;
                st_dw2: begin
                    if (tx_ready) begin
                        state <= st_data;
                        cnt   <= {(hq.len == '0), hq.len};  // 0 means 1024
                    end
                end
                st_data: begin
                    if (tx_xfer) begin
                        cnt <= cnt - 1'b1;
                        if (cnt == 11'd1) state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // payload beats rely on the upstream FIFO holding its word
    a_tx_stable: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && !tx_ready) |=>
            (tx_valid && $stable(tx_data) && $stable(tx_sof) && $stable(tx_eof)));

endmodule

/* verilog/wr_credit_alloc.sv */
`timescale 1ns/1ns

module wr_credit_alloc
    import pcie_wr_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            tlp_h_valid,
    output logic            tlp_h_ready,
    input  tlp_hdr_t        tlp_h,
    input  logic            tlp_d_valid,
    output logic            tlp_d_ready,
    input  logic [31:0]     tlp_d_data,
    output logic            wr_h_valid,
    input  logic            wr_h_ready,
    output tlp_hdr_t        wr_h,
    output logic            wr_d_valid,
    input  logic            wr_d_ready,
    output logic [31:0]     wr_d_data,
    input  logic [FCHB-1:0] fc_ph,
    input  logic [FCDB-1:0] fc_pd,
    input  logic            dma_en
);

    logic [FCHB-1:0] fc_ph_r;
    logic [FCDB-1:0] fc_pd_r;
    logic            tlp_h_xfer;
    logic            h_valid;    // header pending credit check
    logic            h_ready;
    logic            h_xfer;
    tlp_hdr_t        h;
    logic [8:0]      h_need;     // data credits for the pending header
    logic [10:0]     need_pre;
    logic            ph_ok;
    logic            pd_ok;

    always_ff @(posedge clk) begin
        fc_ph_r <= fc_ph;
        fc_pd_r <= fc_pd;
    end

    // payload is not gated here
    assign tlp_d_ready = wr_d_ready;
    assign wr_d_valid  = tlp_d_valid;
    assign wr_d_data   = tlp_d_data;

    assign tlp_h_ready = !h_valid && dma_en;
    assign tlp_h_xfer  = tlp_h_valid && tlp_h_ready;

    // 16 byte units touched by the payload
    assign need_pre = 11'(tlp_h.addr[3:2]) + 11'(tlp_h.len) + 11'd3;

    always_ff @(posedge clk) begin
        if (tlp_h_xfer) begin
            h <= tlp_h;
            if (tlp_h.len == '0) begin
                h_need <= 9'd256;  // 1024 dwords
            end else begin
                h_need <= need_pre[10:2];
            end
        end
    end

    // a set sign bit means infinite or invalid, treat as no credit
    assign ph_ok = !fc_ph_r[FCHB-1] && (fc_ph_r[FCHB-2:0] != '0);
    assign pd_ok = !fc_pd_r[FCDB-1] && (fc_pd_r[FCDB-2:0] >= (FCDB-1)'(h_need));

    assign h_ready = !wr_h_valid && ph_ok && pd_ok;
    assign h_xfer  = h_valid && h_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            h_valid    <= 1'b0;
            wr_h_valid <= 1'b0;
        end else begin
            if (tlp_h_xfer) begin
                h_valid <= 1'b1;
            end else if (h_xfer) begin
                h_valid <= 1'b0;
            end
            if (h_xfer) begin
                wr_h_valid <= 1'b1;
            end else if (wr_h_ready) begin
                wr_h_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (h_xfer) begin
            wr_h <= h;
        end
    end

    a_grant_held: assert property (@(posedge clk) disable iff (rst)
        (wr_h_valid && !wr_h_ready) |=> (wr_h_valid && $stable(wr_h)));

endmodule

/* verilog/wr_tlp_splitter.sv */
`timescale 1ns/1ns

module wr_tlp_splitter
    import pcie_wr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    input  wr_cmd_t     cmd,
    input  logic        wd_valid,
    output logic        wd_ready,
    input  logic [31:0] wd_data,
    output logic        hdr_valid,
    input  logic        hdr_ready,
    output tlp_hdr_t    hdr,
    output logic        d_valid,
    input  logic        d_ready,
    output logic [31:0] d_data
);

    localparam int OFS_W = $clog2(MAX_PAYLOAD_DW);

    logic              busy;          // command in progress
    logic              first;         // next header is the first of the command
    logic [ADDR_W-3:0] cur_addr;      // dword address of next header
    logic [9:0]        remain;        // dwords not yet covered by a header
    logic [3:0]        cmd_be_first;
    logic [3:0]        cmd_be_last;
    logic [9:0]        owed;          // words released by accepted headers
    logic [9:0]        to_bound;
    logic [9:0]        seg_len;
    logic              last_seg;
    logic              cmd_xfer;
    logic              hdr_xfer;
    logic              d_xfer;
    logic              gen_hdr;
    logic              done;

    assign cmd_ready = !busy;
    assign cmd_xfer  = cmd_valid && cmd_ready;
    assign hdr_xfer  = hdr_valid && hdr_ready;
    assign d_xfer    = d_valid && d_ready;

    // payload only moves while an accepted header still owns words
    assign d_valid  = wd_valid && (owed != '0);
    assign wd_ready = d_ready && (owed != '0);
    assign d_data   = wd_data;

    // dwords up to the next 128 byte boundary
    assign to_bound = 10'(MAX_PAYLOAD_DW) - 10'(cur_addr[OFS_W-1:0]);
    assign seg_len  = (remain < to_bound) ? remain : to_bound;
    assign last_seg = (remain == seg_len);

    assign gen_hdr = busy && !hdr_valid && (remain != '0);
    assign done    = busy && !hdr_valid && (remain == '0) && (owed == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            hdr_valid <= 1'b0;
            owed      <= '0;
        end else begin
            if (cmd_xfer) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;  // last word of the command has gone
            end
            if (gen_hdr) begin
                hdr_valid <= 1'b1;
            end else if (hdr_ready) begin
                hdr_valid <= 1'b0;
            end
            owed <= owed + (hdr_xfer ? hdr.len : 10'd0) - 10'(d_xfer);
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_xfer) begin
            cur_addr     <= cmd.addr;
            remain       <= cmd.len;
            first        <= 1'b1;
            cmd_be_first <= cmd.be_first;
            cmd_be_last  <= cmd.be_last;
        end else if (gen_hdr) begin
            hdr.addr     <= cur_addr;
            hdr.len      <= seg_len;
            hdr.be_first <= first ? cmd_be_first : 4'hf;
            if (seg_len == 10'd1) begin
                hdr.be_last <= 4'h0;             // single dword tlp
            end else begin
                hdr.be_last <= last_seg ? cmd_be_last : 4'hf;
            end
            cur_addr     <= cur_addr + (ADDR_W-2)'(seg_len);
            remain       <= remain - seg_len;
            first        <= 1'b0;
        end
    end

    a_cmd_len: assert property (@(posedge clk) disable iff (rst)
        cmd_xfer |-> (cmd.len != '0));

endmodule

/* verilog/sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != (PTR_W+1)'(DEPTH));  // low when full
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= (PTR_W+1)'(DEPTH));

    // a full FIFO never moves its write pointer
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        (count == (PTR_W+1)'(DEPTH)) |=> $stable(wr_ptr));

endmodule

/* verilog/pcie_wr_pkg.sv */
package pcie_wr_pkg;

    localparam int ADDR_W         = 32;  // byte address width
    localparam int FCHB           = 8;   // posted header credit count width
    localparam int FCDB           = 12;  // posted data credit count width
    localparam int MAX_PAYLOAD_DW = 32;  // 128 byte max payload
    localparam int FIFO_DEPTH     = 16;

    // write command from user logic
    typedef struct packed {
        logic [ADDR_W-1:2] addr;      // dword address
        logic [9:0]        len;       // dword count, 1..1023
        logic [3:0]        be_first;
        logic [3:0]        be_last;   // zero for single dword
    } wr_cmd_t;

    // memory write TLP header fields
    typedef struct packed {
        logic [ADDR_W-1:2] addr;
        logic [9:0]        len;       // 0 encodes 1024
        logic [3:0]        be_first;
        logic [3:0]        be_last;
    } tlp_hdr_t;

endpackage
